/* bus_arbiter.sv */
`timescale 1ns/1ns
`include "bus_cfg.svh"

module bus_arbiter import bus_pkg::*; (
    input  logic                      clk_i,
    input  logic                      rst_ni,
    // Master ports
    input  logic [`BUS_NUM_PORTS-1:0] req_valid_i,
    input  bus_req_t                  req_i [`BUS_NUM_PORTS],
    output logic [`BUS_NUM_PORTS-1:0] req_ready_o,
    output logic [`BUS_NUM_PORTS-1:0] rsp_valid_o,
    output bus_rsp_t                  rsp_o,
    input  logic [`BUS_NUM_PORTS-1:0] rsp_ready_i,
    // Memory port
    output logic                      mem_req_valid_o,
    output bus_req_t                  mem_req_o,
    input  logic                      mem_rsp_valid_i,
    input  bus_rsp_t                  mem_rsp_i,
    output logic                      mem_rsp_ready_o
);

    localparam int PORT_W = (`BUS_NUM_PORTS > 1) ? $clog2(`BUS_NUM_PORTS) : 1;
    localparam logic [PORT_W-1:0] LAST_PORT = PORT_W'(`BUS_NUM_PORTS - 1);

    arb_state_e        state_q;
    arb_state_e        state_d;
    logic [PORT_W-1:0] last_q;
    logic [PORT_W-1:0] owner_q;
    logic [PORT_W-1:0] pick;
    logic              any_valid;
    logic              grant;

    //////////////////////////////
    // Round-robin pick
    //////////////////////////////

    // Search begins one past the last granted port
    always_comb begin
        int  idx;
        logic found;
        pick  = last_q;
        found = 1'b0;
        for (int i = 1; i <= `BUS_NUM_PORTS; i++) begin
            idx = (int'(last_q) + i) % `BUS_NUM_PORTS;
            if (!found && req_valid_i[idx]) begin
                found = 1'b1;
                pick  = PORT_W'(idx);
            end
        end
    end

    assign any_valid = |req_valid_i;
    assign grant     = (state_q == ARB_IDLE) && any_valid;

    //////////////////////////////
    // FSM and routing
    //////////////////////////////

    always_comb begin
        state_d         = state_q;
        req_ready_o     = '0;
        rsp_valid_o     = '0;
        mem_req_valid_o = 1'b0;
        mem_rsp_ready_o = 1'b0;
        case (state_q)
            ARB_IDLE: begin
                if (any_valid) begin
                    // Memory is free here, so the handshake completes now
                    req_ready_o[pick] = 1'b1;
                    mem_req_valid_o   = 1'b1;
                    state_d           = ARB_WAIT_RSP;
                end
            end
            ARB_WAIT_RSP, ARB_DELIVER: begin
                rsp_valid_o[owner_q] = mem_rsp_valid_i;
                mem_rsp_ready_o      = rsp_ready_i[owner_q];
                if (mem_rsp_valid_i) begin
                    state_d = rsp_ready_i[owner_q] ? ARB_IDLE : ARB_DELIVER;
                end
            end
            default: state_d = ARB_IDLE;
        endcase
    end

    assign mem_req_o = req_i[pick];
    assign rsp_o     = mem_rsp_i;

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            state_q <= ARB_IDLE;
            last_q  <= LAST_PORT;
            owner_q <= '0;
        end else begin
            state_q <= state_d;
            if (grant) begin
                last_q  <= pick;
                owner_q <= pick;
            end
        end
    end

    // Memory answers in the cycle after the grant and never while idle
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        state_q != ARB_IDLE |-> mem_rsp_valid_i);
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        state_q == ARB_IDLE |-> !mem_rsp_valid_i);

endmodule

/* bus_cfg.svh */
`ifndef BUS_CFG_SVH
`define BUS_CFG_SVH

//////////////////////////////
// Bus geometry
//////////////////////////////

// Word address, one word per location
`define BUS_ADDR_W 8
`define BUS_DATA_W 32

// Full address space is backed by storage
`define BUS_MEM_DEPTH 256

//////////////////////////////
// Monitor and fabric
//////////////////////////////

`define BUS_CNT_W 32
`define BUS_NUM_PORTS 2

`endif

/* bus_memory.sv */
`timescale 1ns/1ns
`include "bus_cfg.svh"

module bus_memory import bus_pkg::*; (
    input  logic     clk_i,
    input  logic     rst_ni,
    input  logic     req_valid_i,
    input  bus_req_t req_i,
    output logic     req_ready_o,
    output logic     rsp_valid_o,
    output bus_rsp_t rsp_o,
    input  logic     rsp_ready_i
);

    logic [`BUS_DATA_W-1:0] mem_q [`BUS_MEM_DEPTH];
    bus_rsp_t               rsp_q;
    logic                   pending_q;
    logic                   req_hs;
    logic                   rsp_hs;

    // One transaction at a time
    assign req_ready_o = ~pending_q;
    assign req_hs      = req_valid_i & req_ready_o;
    assign rsp_hs      = pending_q & rsp_ready_i;

    //////////////////////////////
    // Storage
    //////////////////////////////

    always_ff @(posedge clk_i) begin
        if (req_hs) begin
            if (req_i.write) begin
                mem_q[req_i.addr] <= req_i.wdata;
            end
            // Read data is the word before the write lands
            rsp_q.rdata <= mem_q[req_i.addr];
            rsp_q.wack  <= req_i.write;
        end
    end

    //////////////////////////////
    // Response control
    //////////////////////////////

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            pending_q <= 1'b0;
        end else if (req_hs) begin
            pending_q <= 1'b1;
        end else if (rsp_hs) begin
            pending_q <= 1'b0;
        end
    end

    assign rsp_valid_o = pending_q;
    assign rsp_o       = rsp_q;

    // Upstream lock keeps new requests away until the response is taken
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        pending_q |-> !req_valid_i);

endmodule

/* bus_pkg.sv */
`include "bus_cfg.svh"

package bus_pkg;

    //////////////////////////////
    // Request channel
    //////////////////////////////

    // One word per transfer, no bursts
    typedef struct packed {
        logic                   write;
        logic [`BUS_ADDR_W-1:0] addr;
        logic [`BUS_DATA_W-1:0] wdata;
    } bus_req_t;

    //////////////////////////////
    // Response channel
    //////////////////////////////

    // Read data is only meaningful when wack is low
    typedef struct packed {
        logic [`BUS_DATA_W-1:0] rdata;
        logic                   wack;
    } bus_rsp_t;

    //////////////////////////////
    // Arbiter FSM
    //////////////////////////////

    // IDLE      grant a requester and forward its request
    // WAIT_RSP  memory answers in this cycle
    // DELIVER   response held until the owner takes it
    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_WAIT_RSP,
        ARB_DELIVER
    } arb_state_e;

endpackage

/* bus_snoop.sv */
`timescale 1ns/1ns
`include "bus_cfg.svh"

module bus_snoop import bus_pkg::*; (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    // Master side
    input  logic                  mst_req_valid_i,
    input  bus_req_t              mst_req_i,
    output logic                  mst_req_ready_o,
    output logic                  mst_rsp_valid_o,
    output bus_rsp_t              mst_rsp_o,
    input  logic                  mst_rsp_ready_i,
    // Slave side
    output logic                  slv_req_valid_o,
    output bus_req_t              slv_req_o,
    input  logic                  slv_req_ready_i,
    input  logic                  slv_rsp_valid_i,
    input  bus_rsp_t              slv_rsp_i,
    output logic                  slv_rsp_ready_o,
    // Counters
    output logic [`BUS_CNT_W-1:0] done_count_o,
    output logic [`BUS_CNT_W-1:0] stall_count_o
);

    localparam logic [`BUS_CNT_W-1:0] CNT_ONE = 1;
    localparam logic [`BUS_CNT_W-1:0] CNT_MAX = '1;

    logic [`BUS_CNT_W-1:0] done_q;
    logic [`BUS_CNT_W-1:0] stall_q;
    logic                  rsp_done;
    logic                  rsp_stall;

    // Straight wires in both directions, no added latency
    assign slv_req_valid_o = mst_req_valid_i;
    assign slv_req_o       = mst_req_i;
    assign mst_req_ready_o = slv_req_ready_i;
    assign mst_rsp_valid_o = slv_rsp_valid_i;
    assign mst_rsp_o       = slv_rsp_i;
    assign slv_rsp_ready_o = mst_rsp_ready_i;

    assign rsp_done  = slv_rsp_valid_i & mst_rsp_ready_i;
    assign rsp_stall = slv_rsp_valid_i & ~mst_rsp_ready_i;

    //////////////////////////////
    // Event counters
    //////////////////////////////

    // Both counters stick at all ones
    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            done_q  <= '0;
            stall_q <= '0;
        end else begin
            if (rsp_done && done_q != CNT_MAX) begin
                done_q <= done_q + CNT_ONE;
            end
            if (rsp_stall && stall_q != CNT_MAX) begin
                stall_q <= stall_q + CNT_ONE;
            end
        end
    end

    assign done_count_o  = done_q;
    assign stall_count_o = stall_q;

    // Stalled response must not change or drop before it is taken
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        rsp_stall |=> slv_rsp_valid_i && $stable(slv_rsp_i));

endmodule

/* run.sh */
#!/bin/bash
# Build and run the snoop subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f verilog.f --top-module tb_snoop_top -o sim_snoop
status=$?
if [ $status -ne 0 ]; then
    echo "Build failed"
    exit $status
fi

./obj_dir/sim_snoop
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed"
    exit $status
fi

exit 0

/* snoop_top.sv */
`timescale 1ns/1ns
`include "bus_cfg.svh"

module snoop_top import bus_pkg::*; (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    // Port 0
    input  logic                  req_valid_0_i,
    input  bus_req_t              req_0_i,
    output logic                  req_ready_0_o,
    output logic                  rsp_valid_0_o,
    output bus_rsp_t              rsp_0_o,
    input  logic                  rsp_ready_0_i,
    output logic [`BUS_CNT_W-1:0] done_count_0_o,
    output logic [`BUS_CNT_W-1:0] stall_count_0_o,
    // Port 1
    input  logic                  req_valid_1_i,
    input  bus_req_t              req_1_i,
    output logic                  req_ready_1_o,
    output logic                  rsp_valid_1_o,
    output bus_rsp_t              rsp_1_o,
    input  logic                  rsp_ready_1_i,
    output logic [`BUS_CNT_W-1:0] done_count_1_o,
    output logic [`BUS_CNT_W-1:0] stall_count_1_o
);

    // Snoop to arbiter
    logic [`BUS_NUM_PORTS-1:0] arb_req_valid;
    bus_req_t                  arb_req [`BUS_NUM_PORTS];
    logic [`BUS_NUM_PORTS-1:0] arb_req_ready;
    logic [`BUS_NUM_PORTS-1:0] arb_rsp_valid;
    bus_rsp_t                  arb_rsp;
    logic [`BUS_NUM_PORTS-1:0] arb_rsp_ready;

    // Arbiter to memory
    logic     mem_req_valid;
    bus_req_t mem_req;
    logic     mem_rsp_valid;
    bus_rsp_t mem_rsp;
    logic     mem_rsp_ready;

    bus_snoop u_snoop_0 (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .mst_req_valid_i (req_valid_0_i),
        .mst_req_i       (req_0_i),
        .mst_req_ready_o (req_ready_0_o),
        .mst_rsp_valid_o (rsp_valid_0_o),
        .mst_rsp_o       (rsp_0_o),
        .mst_rsp_ready_i (rsp_ready_0_i),
        .slv_req_valid_o (arb_req_valid[0]),
        .slv_req_o       (arb_req[0]),
        .slv_req_ready_i (arb_req_ready[0]),
        .slv_rsp_valid_i (arb_rsp_valid[0]),
        .slv_rsp_i       (arb_rsp),
        .slv_rsp_ready_o (arb_rsp_ready[0]),
        .done_count_o    (done_count_0_o),
        .stall_count_o   (stall_count_0_o)
    );

    bus_snoop u_snoop_1 (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .mst_req_valid_i (req_valid_1_i),
        .mst_req_i       (req_1_i),
        .mst_req_ready_o (req_ready_1_o),
        .mst_rsp_valid_o (rsp_valid_1_o),
        .mst_rsp_o       (rsp_1_o),
        .mst_rsp_ready_i (rsp_ready_1_i),
        .slv_req_valid_o (arb_req_valid[1]),
        .slv_req_o       (arb_req[1]),
        .slv_req_ready_i (arb_req_ready[1]),
        .slv_rsp_valid_i (arb_rsp_valid[1]),
        .slv_rsp_i       (arb_rsp),
        .slv_rsp_ready_o (arb_rsp_ready[1]),
        .done_count_o    (done_count_1_o),
        .stall_count_o   (stall_count_1_o)
    );

    bus_arbiter u_arbiter (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .req_valid_i     (arb_req_valid),
        .req_i           (arb_req),
        .req_ready_o     (arb_req_ready),
        .rsp_valid_o     (arb_rsp_valid),
        .rsp_o           (arb_rsp),
        .rsp_ready_i     (arb_rsp_ready),
        .mem_req_valid_o (mem_req_valid),
        .mem_req_o       (mem_req),
        .mem_rsp_valid_i (mem_rsp_valid),
        .mem_rsp_i       (mem_rsp),
        .mem_rsp_ready_o (mem_rsp_ready)
    );

    // Arbiter only issues in its idle state, when the memory is always free
    bus_memory u_memory (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .req_valid_i (mem_req_valid),
        .req_i       (mem_req),
        .req_ready_o (),
        .rsp_valid_o (mem_rsp_valid),
        .rsp_o       (mem_rsp),
        .rsp_ready_i (mem_rsp_ready)
    );

endmodule

/* tb_snoop_top.sv */
`timescale 1ns/1ns
`include "bus_cfg.svh"

module tb_snoop_top import bus_pkg::*; ();

    localparam int NUM_TXN   = 100;
    localparam int CYC_LIMIT = 4000;

    logic                  clk_i;
    logic                  rst_ni;
    logic                  req_valid [`BUS_NUM_PORTS];
    bus_req_t              req [`BUS_NUM_PORTS];
    logic                  req_ready [`BUS_NUM_PORTS];
    logic                  rsp_valid [`BUS_NUM_PORTS];
    bus_rsp_t              rsp [`BUS_NUM_PORTS];
    logic                  rsp_ready [`BUS_NUM_PORTS];
    logic [`BUS_CNT_W-1:0] done_count [`BUS_NUM_PORTS];
    logic [`BUS_CNT_W-1:0] stall_count [`BUS_NUM_PORTS];

    // Reference state, updated from observed handshakes
    logic [`BUS_DATA_W-1:0] ref_mem [8];
    logic                   written [8];
    logic                   busy;
    int                     owner;
    int                     last_grant;
    logic                   out_q [`BUS_NUM_PORTS];
    int                     issued [`BUS_NUM_PORTS];
    logic                   pend_write [`BUS_NUM_PORTS];
    logic                   pend_known [`BUS_NUM_PORTS];
    logic [`BUS_DATA_W-1:0] pend_data [`BUS_NUM_PORTS];
    logic [`BUS_CNT_W-1:0]  done_tally [`BUS_NUM_PORTS];
    logic [`BUS_CNT_W-1:0]  stall_tally [`BUS_NUM_PORTS];
    int                     seed;
    int                     cycles;

    snoop_top u_dut (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .req_valid_0_i   (req_valid[0]),
        .req_0_i         (req[0]),
        .req_ready_0_o   (req_ready[0]),
        .rsp_valid_0_o   (rsp_valid[0]),
        .rsp_0_o         (rsp[0]),
        .rsp_ready_0_i   (rsp_ready[0]),
        .done_count_0_o  (done_count[0]),
        .stall_count_0_o (stall_count[0]),
        .req_valid_1_i   (req_valid[1]),
        .req_1_i         (req[1]),
        .req_ready_1_o   (req_ready[1]),
        .rsp_valid_1_o   (rsp_valid[1]),
        .rsp_1_o         (rsp[1]),
        .rsp_ready_1_i   (rsp_ready[1]),
        .done_count_1_o  (done_count[1]),
        .stall_count_1_o (stall_count[1])
    );

    always #50 clk_i = ~clk_i;

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("Error at %0t: %s expected %h actual %h", $time, name, exp, act);
        $display("STATUS: FAIL");
        $fatal(1);
    endtask

    task automatic abort_run(input string msg);
        $display("%s at %0t", msg, $time);
        $display("STATUS: FAIL");
        $fatal(1);
    endtask

    //////////////////////////////
    // Stimulus and reference model
    //////////////////////////////

    always @(posedge clk_i) begin
        int r;
        if (!rst_ni) begin
            busy       <= 1'b0;
            owner      <= 0;
            last_grant <= `BUS_NUM_PORTS - 1;
            for (int a = 0; a < 8; a++) begin
                written[a] <= 1'b0;
            end
            for (int p = 0; p < `BUS_NUM_PORTS; p++) begin
                out_q[p]       <= 1'b0;
                issued[p]      <= 0;
                pend_write[p]  <= 1'b0;
                pend_known[p]  <= 1'b0;
                done_tally[p]  <= '0;
                stall_tally[p] <= '0;
            end
        end else begin
            for (int p = 0; p < `BUS_NUM_PORTS; p++) begin
                if (rsp_valid[p] && rsp_ready[p]) begin
                    done_tally[p] <= done_tally[p] + 1;
                    busy          <= 1'b0;
                    out_q[p]      <= 1'b0;
                end
                if (rsp_valid[p] && !rsp_ready[p]) begin
                    stall_tally[p] <= stall_tally[p] + 1;
                end
                if (req_valid[p] && req_ready[p]) begin
                    busy          <= 1'b1;
                    owner         <= p;
                    last_grant    <= p;
                    out_q[p]      <= 1'b1;
                    issued[p]     <= issued[p] + 1;
                    req_valid[p]  <= 1'b0;
                    pend_write[p] <= req[p].write;
                    pend_data[p]  <= ref_mem[req[p].addr[2:0]];
                    pend_known[p] <= written[req[p].addr[2:0]];
                    if (req[p].write) begin
                        ref_mem[req[p].addr[2:0]] <= req[p].wdata;
                        written[req[p].addr[2:0]] <= 1'b1;
                    end
                end else if (!req_valid[p] && !out_q[p] && issued[p] < NUM_TXN) begin
                    r = $random(seed);
                    if (r[1:0] != 2'b00) begin
                        // Eight addresses so reads mostly hit written words
                        req_valid[p]    <= 1'b1;
                        req[p].write    <= r[2];
                        req[p].addr     <= {5'b0, r[5:3]};
                        req[p].wdata    <= $random(seed);
                    end
                end
                r = $random(seed);
                rsp_ready[p] <= (r[1:0] != 2'b00);
            end
        end
    end

    //////////////////////////////
    // Checks
    //////////////////////////////

    for (genvar p = 0; p < `BUS_NUM_PORTS; p++) begin : g_chk
        assert property (@(posedge clk_i) disable iff (!rst_ni)
            rsp_valid[p] && pend_write[p] |-> rsp[p].wack)
            else report_mismatch($sformatf("rsp_%0d_o.wack", p), 1, $sampled(rsp[p].wack));
        assert property (@(posedge clk_i) disable iff (!rst_ni)
            rsp_valid[p] && !pend_write[p] && pend_known[p] |-> rsp[p].rdata == pend_data[p])
            else report_mismatch($sformatf("rsp_%0d_o.rdata", p), $sampled(pend_data[p]),
                                 $sampled(rsp[p].rdata));
        assert property (@(posedge clk_i) disable iff (!rst_ni)
            req_valid[p] && req_ready[p] |=> rsp_valid[p])
            else abort_run($sformatf("Port %0d response did not follow its request", p));
        assert property (@(posedge clk_i) disable iff (!rst_ni)
            rsp_valid[p] |-> busy && owner == p)
            else abort_run($sformatf("Port %0d got a response it did not own", p));
        assert property (@(posedge clk_i) disable iff (!rst_ni)
            busy |-> !req_ready[p])
            else abort_run($sformatf("Port %0d granted while a transaction was open", p));
        assert property (@(posedge clk_i) disable iff (!rst_ni)
            rsp_valid[p] && !rsp_ready[p] |=> rsp_valid[p] && $stable(rsp[p]))
            else abort_run($sformatf("Port %0d stalled response changed", p));
        assert property (@(posedge clk_i) disable iff (!rst_ni)
            done_count[p] == done_tally[p])
            else report_mismatch($sformatf("done_count_%0d_o", p), $sampled(done_tally[p]),
                                 $sampled(done_count[p]));
        assert property (@(posedge clk_i) disable iff (!rst_ni)
            stall_count[p] == stall_tally[p])
            else report_mismatch($sformatf("stall_count_%0d_o", p), $sampled(stall_tally[p]),
                                 $sampled(stall_count[p]));
    end

    // Round robin, the port not granted last wins a tie
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        req_valid[0] && req_valid[1] && !busy |-> req_ready[last_grant == 0 ? 1 : 0])
        else abort_run("Tie was not granted to the other port");

    always @(posedge clk_i) begin
        cycles <= cycles + 1;
        if (cycles >= CYC_LIMIT) begin
            abort_run("Run did not finish within the cycle limit");
        end
    end

    initial begin
        seed   = 43;
        cycles = 0;
        clk_i  = 1'b0;
        rst_ni = 1'b0;
        for (int p = 0; p < `BUS_NUM_PORTS; p++) begin
            req_valid[p] = 1'b0;
            req[p]       = '0;
            rsp_ready[p] = 1'b0;
        end
        repeat (5) @(posedge clk_i);
        rst_ni <= 1'b1;
        @(posedge clk_i);
        for (int p = 0; p < `BUS_NUM_PORTS; p++) begin
            if (req_ready[p] || rsp_valid[p] || done_count[p] != 0 || stall_count[p] != 0) begin
                abort_run($sformatf("Port %0d not idle after reset", p));
            end
        end
        while (!(issued[0] == NUM_TXN && issued[1] == NUM_TXN && !out_q[0] && !out_q[1])) begin
            @(posedge clk_i);
        end
        @(posedge clk_i);
        if (done_count[0] == NUM_TXN && done_count[1] == NUM_TXN &&
            stall_count[0] == stall_tally[0] && stall_count[1] == stall_tally[1]) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            abort_run("Final counter values do not match the tallies");
        end
    end

endmodule

/* verilog.f */
+incdir+.
bus_pkg.sv
bus_snoop.sv
bus_arbiter.sv
bus_memory.sv
snoop_top.sv
tb_snoop_top.sv
